// ==== list.f ====
common/regfile_pkg.sv
verilog/regfile_decode.sv
reg_bank/gpr_bank.sv
reg_bank/status_reg.sv
verilog/read_mux.sv
verilog/pu_register_file.sv
verif/register_file_checker.sv
verif/tb_register_file.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the register file simulation with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -f list.f --top-module tb_register_file \
  --Mdir "$build_dir" -o vsim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./"$build_dir"/vsim > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "sim passed" "$log_file"; then
  exit 0
fi
echo "Pass message not found in $log_file"
exit 1

// ==== verif/tb_register_file.sv ====
// Directed testbench for the register file top level
// Each test task drives the DUT and compares against a local register model

`timescale 1ns/1ps

module tb_register_file;

  localparam int num_tests = 5;
  localparam int timeout_ns = num_tests * 40 * 40;  // 40 cycles of 40 ns per test
  localparam logic [15:0] sr_keep = 16'h01bf;        // Stored R2 bits

  logic        mclk_r1;
  logic        puc_rst;
  logic [15:0] inst_src, inst_dest, reg_dest_val, reg_sp_val, pc;
  logic        reg_dest_wr, reg_incr, reg_sp_wr, reg_sr_wr, reg_sr_clr, reg_pc_call;
  logic        inst_bw;
  logic [3:0]  alu_stat, alu_stat_wr;
  logic [15:0] reg_src, reg_dest, sp, pc_sw;
  logic        pc_sw_wr, gie, cpuoff, oscoff, scg0, scg1;
  logic [3:0]  status;

  integer      seed = 38547;
  int          err_count = 0;
  int          check_count = 0;
  logic [15:0] model [16];  // Expected contents, slot 0 mirrors pc

  pu_register_file dut (
    .mclk_r1 (mclk_r1), .puc_rst (puc_rst), .inst_src (inst_src), .inst_dest (inst_dest),
    .reg_dest_wr (reg_dest_wr), .reg_incr (reg_incr), .reg_sp_wr (reg_sp_wr),
    .reg_sr_wr (reg_sr_wr), .reg_sr_clr (reg_sr_clr), .reg_pc_call (reg_pc_call),
    .reg_dest_val (reg_dest_val), .reg_sp_val (reg_sp_val), .pc (pc),
    .alu_stat (alu_stat), .alu_stat_wr (alu_stat_wr), .inst_bw (inst_bw),
    .reg_src (reg_src), .reg_dest (reg_dest), .sp (sp), .pc_sw (pc_sw),
    .pc_sw_wr (pc_sw_wr), .status (status), .gie (gie), .cpuoff (cpuoff),
    .oscoff (oscoff), .scg0 (scg0), .scg1 (scg1)
  );

  initial begin
    mclk_r1 = 1'b0;
    forever #20 mclk_r1 = ~mclk_r1;  // 40 ns period
  end

  // Watchdog
  initial begin
    #(timeout_ns);
    $display("ERROR: run timed out after %0d ns", timeout_ns);
    $display("sim failed");
    $finish;
  end

  // ---------------------------------------------------------------------
  // Helpers
  // ---------------------------------------------------------------------
  task automatic check_val(input logic [15:0] actual, input logic [15:0] expected,
                           input string msg);
    check_count++;
    if (actual !== expected) begin
      err_count++;
      $display("CHECK FAILED @%0t: %s got %h expected %h", $time, msg, actual, expected);
    end
  endtask

  function automatic logic [15:0] onehot(input int idx);
    return 16'h0001 << idx;
  endfunction

  task automatic clear_strobes();
    reg_dest_wr <= 1'b0;
    reg_incr    <= 1'b0;
    reg_sp_wr   <= 1'b0;
    reg_sr_wr   <= 1'b0;
    reg_sr_clr  <= 1'b0;
    reg_pc_call <= 1'b0;
    inst_bw     <= 1'b0;
    alu_stat_wr <= 4'h0;
  endtask

  task automatic write_reg(input int idx, input logic [15:0] val, input logic bw);
    @(posedge mclk_r1);
    inst_dest    <= onehot(idx);
    reg_dest_val <= val;
    inst_bw      <= bw;
    reg_dest_wr  <= 1'b1;
    @(posedge mclk_r1);  // Taken at this edge
    clear_strobes();
  endtask

  task automatic sp_load(input logic [15:0] val);
    @(posedge mclk_r1);
    reg_sp_val <= val;
    reg_sp_wr  <= 1'b1;
    @(posedge mclk_r1);
    clear_strobes();
  endtask

  task automatic incr_reg(input int idx, input logic bw);
    @(posedge mclk_r1);
    inst_src <= onehot(idx);
    inst_bw  <= bw;
    reg_incr <= 1'b1;
    @(posedge mclk_r1);
    clear_strobes();
  endtask

  // Reads one register on both ports, sampled mid-cycle
  task automatic read_check(input int idx, input string msg);
    @(posedge mclk_r1);
    inst_src  <= onehot(idx);
    inst_dest <= onehot(idx);
    @(negedge mclk_r1);
    check_val(reg_src, model[idx], $sformatf("R%0d src %s", idx, msg));
    check_val(reg_dest, model[idx], $sformatf("R%0d dest %s", idx, msg));
  endtask

  // ---------------------------------------------------------------------
  // Tests
  // ---------------------------------------------------------------------
  task automatic test_reset();
    for (int i = 0; i < 16; i++) begin
      read_check(i, "after reset");
    end
    check_val({11'h0, gie, cpuoff, oscoff, scg0, scg1}, 16'h0, "low-power bits after reset");
    check_val({12'h0, status}, 16'h0, "flags after reset");
    check_val({15'h0, pc_sw_wr}, 16'h0, "pc_sw_wr after reset");
    check_val(sp, 16'h0, "sp after reset");
  endtask

  task automatic test_writes();
    logic [15:0] v;
    for (int i = 4; i < 16; i++) begin
      v = 16'($random(seed));
      write_reg(i, v, 1'b0);
      model[i] = v;
      read_check(i, "word write");
    end
    v = 16'($random(seed));
    write_reg(9, v, 1'b1);
    model[9] = {8'h00, v[7:0]};  // Upper byte cleared
    read_check(9, "byte write");
    v = 16'($random(seed));
    write_reg(3, v, 1'b0);
    model[3] = v;
    read_check(3, "constant generator write");
  endtask

  task automatic test_autoincr();
    logic [15:0] v;
    incr_reg(6, 1'b0);
    model[6] += 16'd2;
    read_check(6, "word increment");
    incr_reg(7, 1'b1);
    model[7] += 16'd1;
    read_check(7, "byte increment");
    v = 16'($random(seed)) | 16'h0001;  // Odd on purpose
    write_reg(1, v, 1'b0);
    model[1] = v & 16'hfffe;
    read_check(1, "odd destination write");
    incr_reg(1, 1'b1);
    model[1] += 16'd2;  // SP steps by 2 even in byte mode
    read_check(1, "byte increment");
    v = 16'($random(seed)) | 16'h0001;
    sp_load(v);
    model[1] = v & 16'hfffe;
    read_check(1, "odd stack write");
    check_val(sp, model[1], "sp output");
    incr_reg(1, 1'b0);
    model[1] += 16'd2;
    read_check(1, "word increment");
    incr_reg(3, 1'b0);
    read_check(3, "after increment");
    // Write and increment on the same register
    v = 16'($random(seed));
    @(posedge mclk_r1);
    inst_src     <= onehot(8);
    inst_dest    <= onehot(8);
    reg_dest_val <= v;
    reg_dest_wr  <= 1'b1;
    reg_incr     <= 1'b1;
    @(posedge mclk_r1);
    clear_strobes();
    model[8] = v;
    read_check(8, "write beats increment");
  endtask

  task automatic test_status();
    logic [15:0] v;
    logic [3:0]  flags;
    logic [3:0]  upd;
    v = 16'($random(seed)) | 16'h0040;  // Sets scg0 so the mask matters
    write_reg(2, v, 1'b0);
    model[2] = v & sr_keep;
    read_check(2, "masked write");
    check_val({11'h0, gie, cpuoff, oscoff, scg0, scg1},
              {11'h0, v[3], v[4], v[5], 1'b0, v[7]}, "low-power bits follow R2");
    check_val({12'h0, status}, {12'h0, v[8], v[2], v[1], v[0]}, "flags follow R2");
    write_reg(2, 16'h0000, 1'b0);
    model[2] = 16'h0000;
    read_check(2, "cleared");
    check_val({15'h0, cpuoff}, 16'h0, "cpuoff low before write");
    @(posedge mclk_r1);
    inst_dest    <= onehot(2);
    reg_dest_val <= 16'h0010;
    reg_dest_wr  <= 1'b1;
    @(negedge mclk_r1);
    check_val({15'h0, cpuoff}, 16'h1, "cpuoff in write cycle");  // Before the edge
    @(posedge mclk_r1);
    clear_strobes();
    model[2] = 16'h0010;
    read_check(2, "cpuoff stored");
    for (int n = 0; n < 2; n++) begin
      v = 16'($random(seed));
      write_reg(2, v, 1'b0);
      model[2] = v & sr_keep;
      flags = 4'($random(seed));
      upd   = (n == 0) ? 4'b1010 : 4'($random(seed));
      @(posedge mclk_r1);
      alu_stat    <= flags;
      alu_stat_wr <= upd;
      @(posedge mclk_r1);
      clear_strobes();
      if (upd[0]) model[2][0] = flags[0];
      if (upd[1]) model[2][1] = flags[1];
      if (upd[2]) model[2][2] = flags[2];
      if (upd[3]) model[2][8] = flags[3];
      read_check(2, "ALU flag update");
    end
    write_reg(2, 16'h01af, 1'b0);
    model[2] = 16'h01af & sr_keep;
    @(posedge mclk_r1);
    reg_sr_clr <= 1'b1;
    inst_src   <= onehot(5);  // Overridden by the clear
    inst_dest  <= onehot(5);
    @(negedge mclk_r1);
    check_val(reg_src, model[2], "source forced to R2 on clear");
    @(posedge mclk_r1);
    clear_strobes();
    model[2] = 16'h0000;
    read_check(2, "after interrupt clear");
    check_val({15'h0, gie}, 16'h0, "gie after interrupt clear");
  endtask

  task automatic test_pc();
    logic [15:0] v;
    @(posedge mclk_r1);
    v = 16'($random(seed));
    pc <= v;
    model[0] = v;
    read_check(0, "pc view");
    v = 16'($random(seed));
    @(posedge mclk_r1);
    inst_dest    <= onehot(0);
    reg_dest_val <= v;
    reg_dest_wr  <= 1'b1;
    inst_bw      <= 1'b1;
    @(negedge mclk_r1);
    check_val({15'h0, pc_sw_wr}, 16'h1, "pc_sw_wr on R0 write");
    check_val(pc_sw, {8'h00, v[7:0]}, "pc_sw byte write");
    @(posedge mclk_r1);
    clear_strobes();
    @(negedge mclk_r1);
    check_val({15'h0, pc_sw_wr}, 16'h0, "pc_sw_wr idle");
    v = 16'($random(seed));
    @(posedge mclk_r1);
    inst_dest    <= 16'h0000;
    reg_dest_val <= v;
    reg_pc_call  <= 1'b1;
    @(negedge mclk_r1);
    check_val({15'h0, pc_sw_wr}, 16'h1, "pc_sw_wr on call");
    check_val(pc_sw, v, "pc_sw word write");
    @(posedge mclk_r1);
    clear_strobes();
  endtask

  initial begin
    inst_src     <= 16'h0000;
    inst_dest    <= 16'h0000;
    reg_dest_val <= 16'h0000;
    reg_sp_val   <= 16'h0000;
    pc           <= 16'hc000;
    alu_stat     <= 4'h0;
    puc_rst      <= 1'b1;
    clear_strobes();
    for (int i = 0; i < 16; i++) begin
      model[i] = 16'h0000;
    end
    model[0] = 16'hc000;
    repeat (8) @(posedge mclk_r1);
    puc_rst <= 1'b0;
    test_reset();
    test_writes();
    test_autoincr();
    test_status();
    test_pc();
    $display("checks=%0d errors=%0d", check_count, err_count);
    if (err_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== verif/register_file_checker.sv ====
// Concurrent assertions on the register file top level
// Attached to every pu_register_file by the bind below

`timescale 1ns/1ps

module register_file_checker import regfile_pkg::*; (
  input logic             mclk_r1,
  input logic             puc_rst,
  input logic [reg_w-1:0] sp,
  input sr_word_t         sr_q,
  input logic [reg_w-1:0] inst_dest,
  input logic             reg_dest_wr,
  input logic             reg_pc_call,
  input logic             reg_sr_clr,
  input logic             pc_sw_wr
);

  a_sp_even: assert property (@(posedge mclk_r1) disable iff (puc_rst) sp[0] == 1'b0)
    else $error("stack pointer bit 0 set");

  // Reserved bits and scg0 never stored
  a_sr_rsvd: assert property (@(posedge mclk_r1) disable iff (puc_rst)
    sr_q.f.rsvd == '0 && sr_q.f.scg0 == 1'b0)
    else $error("reserved status bit set");

  a_pc_sw_wr: assert property (@(posedge mclk_r1) disable iff (puc_rst)
    pc_sw_wr == ((inst_dest[pc_idx] & reg_dest_wr) | reg_pc_call))
    else $error("pc_sw_wr does not match its requests");

  a_sr_clr: assert property (@(posedge mclk_r1) disable iff (puc_rst)
    reg_sr_clr |=> sr_q.word == '0)
    else $error("status word not cleared");

endmodule

bind pu_register_file register_file_checker u_checker (
  .mclk_r1 (mclk_r1), .puc_rst (puc_rst), .sp (sp), .sr_q (sr_q), .inst_dest (inst_dest),
  .reg_dest_wr (reg_dest_wr), .reg_pc_call (reg_pc_call), .reg_sr_clr (reg_sr_clr),
  .pc_sw_wr (pc_sw_wr)
);

// ==== verilog/pu_register_file.sv ====
// Top of the 16-word register file for the CPU core
// Decode, register storage, status register and read ports

`timescale 1ns/1ps

module pu_register_file import regfile_pkg::*; #(
  parameter logic [reg_w-1:0] sr_mask = sr_mask_fpga
) (
  input  logic             mclk_r1,
  input  logic             puc_rst,
  input  logic [reg_w-1:0] inst_src,      // One-hot source selection
  input  logic [reg_w-1:0] inst_dest,     // One-hot destination selection
  input  logic             reg_dest_wr,
  input  logic             reg_incr,
  input  logic             reg_sp_wr,
  input  logic             reg_sr_wr,     // RETI restore
  input  logic             reg_sr_clr,    // Interrupt entry
  input  logic             reg_pc_call,
  input  logic [reg_w-1:0] reg_dest_val,
  input  logic [reg_w-1:0] reg_sp_val,
  input  logic [reg_w-1:0] pc,
  input  logic [3:0]       alu_stat,      // {V,N,Z,C}
  input  logic [3:0]       alu_stat_wr,
  input  logic             inst_bw,
  output logic [reg_w-1:0] reg_src,
  output logic [reg_w-1:0] reg_dest,
  output logic [reg_w-1:0] sp,
  output logic [reg_w-1:0] pc_sw,
  output logic             pc_sw_wr,
  output logic [3:0]       status,
  output logic             gie,
  output logic             cpuoff,
  output logic             oscoff,
  output logic             scg0,
  output logic             scg1
);

  // ---------------------------------------------------------------------
  // Internal nets
  // ---------------------------------------------------------------------
  logic [reg_w-1:0]          src_sel;
  logic [reg_w-1:0]          dest_wr_en;
  logic [reg_w-1:0]          inc_en;
  logic [reg_w-1:0]          dest_val_in;
  logic [1:0]                incr_step;
  logic                      sr_wr;
  sr_word_t                  sr_q;
  logic [num_regs*reg_w-1:0] bank_q;

  regfile_decode u_decode (
    .inst_src     (inst_src),
    .inst_dest    (inst_dest),
    .reg_dest_val (reg_dest_val),
    .reg_dest_wr  (reg_dest_wr),
    .reg_incr     (reg_incr),
    .reg_sr_clr   (reg_sr_clr),
    .reg_sr_wr    (reg_sr_wr),
    .reg_pc_call  (reg_pc_call),
    .inst_bw      (inst_bw),
    .src_sel      (src_sel),
    .dest_wr_en   (dest_wr_en),
    .inc_en       (inc_en),
    .dest_val_in  (dest_val_in),
    .pc_sw        (pc_sw),
    .incr_step    (incr_step),
    .sr_wr        (sr_wr),
    .pc_sw_wr     (pc_sw_wr)
  );

  gpr_bank u_bank (
    .mclk_r1     (mclk_r1),
    .puc_rst     (puc_rst),
    .dest_wr_en  (dest_wr_en),
    .inc_en      (inc_en),
    .dest_val_in (dest_val_in),
    .reg_sp_val  (reg_sp_val),
    .reg_src     (reg_src),    // Feeds the autoincrement adder
    .pc          (pc),
    .incr_step   (incr_step),
    .reg_sp_wr   (reg_sp_wr),
    .sr_q        (sr_q),
    .bank_q      (bank_q),
    .sp          (sp)
  );

  status_reg #(.sr_mask(sr_mask)) u_status (
    .mclk_r1     (mclk_r1),
    .puc_rst     (puc_rst),
    .dest_val_in (dest_val_in),
    .alu_stat    (alu_stat),
    .alu_stat_wr (alu_stat_wr),
    .sr_wr       (sr_wr),
    .reg_sr_clr  (reg_sr_clr),
    .sr_q        (sr_q),
    .status      (status),
    .gie         (gie),
    .cpuoff      (cpuoff),
    .oscoff      (oscoff),
    .scg0        (scg0),
    .scg1        (scg1)
  );

  read_mux u_read (
    .bank_q    (bank_q),
    .src_sel   (src_sel),
    .inst_dest (inst_dest),
    .reg_src   (reg_src),
    .reg_dest  (reg_dest)
  );

endmodule

// ==== verilog/read_mux.sv ====
// Source and destination read ports of the register file
// AND-OR one-hot selection over the flat register bus

`timescale 1ns/1ps

module read_mux import regfile_pkg::*; (
  input  logic [num_regs*reg_w-1:0] bank_q,
  input  logic [reg_w-1:0]          src_sel,    // One-hot, R2 forced on interrupt
  input  logic [reg_w-1:0]          inst_dest,  // One-hot
  output logic [reg_w-1:0]          reg_src,
  output logic [reg_w-1:0]          reg_dest
);

  // Empty selection gives zero
  function automatic logic [reg_w-1:0] onehot_read(
    input logic [num_regs*reg_w-1:0] q,
    input logic [reg_w-1:0]          sel
  );
    logic [reg_w-1:0] acc;
    acc = '0;
    for (int i = 0; i < num_regs; i++) begin
      acc |= q[i*reg_w +: reg_w] & {reg_w{sel[i]}};
    end
    return acc;
  endfunction

  assign reg_src  = onehot_read(bank_q, src_sel);
  assign reg_dest = onehot_read(bank_q, inst_dest);

endmodule

// ==== reg_bank/status_reg.sv ====
// R2 status register with ALU flag update, write mask and low-power controls
// sr_mask selects which bits the build keeps

`timescale 1ns/1ps

module status_reg import regfile_pkg::*; #(
  parameter logic [reg_w-1:0] sr_mask = sr_mask_fpga
) (
  input  logic             mclk_r1,
  input  logic             puc_rst,
  input  logic [reg_w-1:0] dest_val_in,
  input  logic [3:0]       alu_stat,     // {V,N,Z,C}
  input  logic [3:0]       alu_stat_wr,  // Per-flag update enable
  input  logic             sr_wr,
  input  logic             reg_sr_clr,   // Interrupt entry
  output sr_word_t         sr_q,
  output logic [3:0]       status,
  output logic             gie,
  output logic             cpuoff,
  output logic             oscoff,
  output logic             scg0,
  output logic             scg1
);

  sr_word_t sr_nxt;

  // ---------------------------------------------------------------------
  // Next value
  // ---------------------------------------------------------------------
  always_comb begin
    sr_nxt.word = '0;  // Reserved bits stay clear
    // ALU flags win over written data, bit by bit
    sr_nxt.word[sr_c_bit] = alu_stat_wr[0] ? alu_stat[0] :
                            sr_wr          ? dest_val_in[sr_c_bit] : sr_q.word[sr_c_bit];
    sr_nxt.word[sr_z_bit] = alu_stat_wr[1] ? alu_stat[1] :
                            sr_wr          ? dest_val_in[sr_z_bit] : sr_q.word[sr_z_bit];
    sr_nxt.word[sr_n_bit] = alu_stat_wr[2] ? alu_stat[2] :
                            sr_wr          ? dest_val_in[sr_n_bit] : sr_q.word[sr_n_bit];
    sr_nxt.word[sr_v_bit] = alu_stat_wr[3] ? alu_stat[3] :
                            sr_wr          ? dest_val_in[sr_v_bit] : sr_q.word[sr_v_bit];
    // Control bits only change by a full write
    sr_nxt.word[sr_scg1_bit:sr_gie_bit] = sr_wr ? dest_val_in[sr_scg1_bit:sr_gie_bit]
                                                : sr_q.word[sr_scg1_bit:sr_gie_bit];
  end

  always_ff @(posedge mclk_r1 or posedge puc_rst) begin
    if (puc_rst)         sr_q.word <= '0;
    else if (reg_sr_clr) sr_q.word <= '0;  // Clears GIE and wakes the CPU
    else                 sr_q.word <= sr_nxt.word & sr_mask;
  end

  // ---------------------------------------------------------------------
  // Outputs
  // ---------------------------------------------------------------------
  assign status = {sr_q.f.v, sr_q.f.n, sr_q.f.z, sr_q.f.c};
  assign gie    = sr_q.f.gie;
  assign oscoff = sr_q.f.oscoff;
  assign scg0   = sr_q.f.scg0;
  assign scg1   = sr_q.f.scg1;

  // Stop fetch in the write cycle itself
  assign cpuoff = sr_q.f.cpuoff |
                  (dest_val_in[sr_cpuoff_bit] & sr_wr & sr_mask[sr_cpuoff_bit]);

endmodule

// ==== reg_bank/gpr_bank.sv ====
// Register storage for R1, R3 and R4 to R15, plus the flat read bus
// R0 and R2 enter from outside and only fill their bus slots

`timescale 1ns/1ps

module gpr_bank import regfile_pkg::*; (
  input  logic                      mclk_r1,
  input  logic                      puc_rst,
  input  logic [reg_w-1:0]          dest_wr_en,  // Per-register write
  input  logic [reg_w-1:0]          inc_en,      // Per-register autoincrement
  input  logic [reg_w-1:0]          dest_val_in,
  input  logic [reg_w-1:0]          reg_sp_val,  // Stack pointer next value
  input  logic [reg_w-1:0]          reg_src,     // Current source read
  input  logic [reg_w-1:0]          pc,
  input  logic [1:0]                incr_step,
  input  logic                      reg_sp_wr,
  input  sr_word_t                  sr_q,
  output logic [num_regs*reg_w-1:0] bank_q,      // Slot i holds Ri
  output logic [reg_w-1:0]          sp
);

  localparam logic [reg_w-1:0] even_mask = {{(reg_w-1){1'b1}}, 1'b0};

  logic [reg_w-1:0] incr_val;

  // Autoincrement adds to whatever the source port reads
  assign incr_val = reg_src + {{(reg_w-2){1'b0}}, incr_step};

  // ---------------------------------------------------------------------
  // Per-slot storage
  // ---------------------------------------------------------------------
  for (genvar i = 0; i < num_regs; i++) begin : g_slot
    if (i == pc_idx) begin : g_pc
      assign bank_q[i*reg_w +: reg_w] = pc;         // R0 lives in the fetch unit
    end else if (i == sr_idx) begin : g_sr
      assign bank_q[i*reg_w +: reg_w] = sr_q.word;  // R2 lives in status_reg
    end else if (i == sp_idx) begin : g_sp
      logic [reg_w-1:0] q;
      always_ff @(posedge mclk_r1 or posedge puc_rst) begin
        if (puc_rst)            q <= '0;
        else if (dest_wr_en[i]) q <= dest_val_in & even_mask;
        else if (reg_sp_wr)     q <= reg_sp_val & even_mask;  // Push or pop
        else if (inc_en[i])     q <= incr_val & even_mask;
      end
      assign bank_q[i*reg_w +: reg_w] = q;
      assign sp = q;
    end else if (i == cg_idx) begin : g_cg
      // @R3+ encodes the constant -1, so no increment here
      logic [reg_w-1:0] q;
      always_ff @(posedge mclk_r1 or posedge puc_rst) begin
        if (puc_rst)            q <= '0;
        else if (dest_wr_en[i]) q <= dest_val_in;
      end
      assign bank_q[i*reg_w +: reg_w] = q;
    end else begin : g_gpr
      logic [reg_w-1:0] q;
      always_ff @(posedge mclk_r1 or posedge puc_rst) begin
        if (puc_rst)            q <= '0;
        else if (dest_wr_en[i]) q <= dest_val_in;  // Write beats increment
        else if (inc_en[i])     q <= incr_val;
      end
      assign bank_q[i*reg_w +: reg_w] = q;
    end
  end

endmodule

// ==== verilog/regfile_decode.sv ====
// Selection decode for the register file
// Turns one-hot selections and strobes into per-register enables and write data

`timescale 1ns/1ps

module regfile_decode import regfile_pkg::*; (
  input  logic [reg_w-1:0] inst_src,     // One-hot source selection
  input  logic [reg_w-1:0] inst_dest,    // One-hot destination selection
  input  logic [reg_w-1:0] reg_dest_val, // Raw destination data
  input  logic             reg_dest_wr,
  input  logic             reg_incr,
  input  logic             reg_sr_clr,
  input  logic             reg_sr_wr,
  input  logic             reg_pc_call,
  input  logic             inst_bw,      // Byte access
  output logic [reg_w-1:0] src_sel,
  output logic [reg_w-1:0] dest_wr_en,
  output logic [reg_w-1:0] inc_en,
  output logic [reg_w-1:0] dest_val_in,
  output logic [reg_w-1:0] pc_sw,
  output logic [1:0]       incr_step,
  output logic             sr_wr,
  output logic             pc_sw_wr
);

  // ---------------------------------------------------------------------
  // Source selection
  // ---------------------------------------------------------------------
  // Interrupt entry reads R2 for the push
  assign src_sel = reg_sr_clr ? reg_w'(1) << sr_idx : inst_src;

  // Strobe gating
  assign dest_wr_en = inst_dest & {reg_w{reg_dest_wr}};
  assign inc_en     = src_sel & {reg_w{reg_incr}};

  // Byte mode clears the upper byte
  assign dest_val_in = inst_bw ? {8'h00, reg_dest_val[7:0]} : reg_dest_val;

  // SP stays word aligned even for @SP+ byte accesses
  assign incr_step = (inst_bw & ~src_sel[sp_idx]) ? 2'd1 : 2'd2;

  // R2 load from MOV to SR or from RETI
  assign sr_wr = dest_wr_en[sr_idx] | reg_sr_wr;

  // ---------------------------------------------------------------------
  // Software PC update
  // ---------------------------------------------------------------------
  assign pc_sw    = dest_val_in;                          // Byte masked like any write
  assign pc_sw_wr = dest_wr_en[pc_idx] | reg_pc_call;    // Branch or CALL

endmodule

// ==== common/regfile_pkg.sv ====
// Shared widths, register indices and status word layout for the register file
// Imported by every module of the register file

package regfile_pkg;

  // Datapath sizes
  parameter int reg_w    = 16;
  parameter int num_regs = 16;

  // Special register slots
  parameter int pc_idx = 0;  // Program counter view
  parameter int sp_idx = 1;  // Stack pointer
  parameter int sr_idx = 2;  // Status register
  parameter int cg_idx = 3;  // Constant generator

  // ---------------------------------------------------------------------
  // Status register bit positions
  // ---------------------------------------------------------------------
  parameter int sr_c_bit      = 0;
  parameter int sr_z_bit      = 1;
  parameter int sr_n_bit      = 2;
  parameter int sr_gie_bit    = 3;
  parameter int sr_cpuoff_bit = 4;
  parameter int sr_oscoff_bit = 5;
  parameter int sr_scg0_bit   = 6;
  parameter int sr_scg1_bit   = 7;
  parameter int sr_v_bit      = 8;

  // FPGA build, no DCO control so scg0 is never stored
  parameter logic [reg_w-1:0] sr_mask_fpga = 16'h01bf;

  // R2 seen as a plain word or as named flags
  typedef union packed {
    logic [reg_w-1:0] word;
    struct packed {
      logic [6:0] rsvd;   // Always zero
      logic       v;      // Overflow
      logic       scg1;   // SMCLK off
      logic       scg0;   // DCO off
      logic       oscoff; // LFXT1 off
      logic       cpuoff; // CPU off
      logic       gie;    // Interrupt enable
      logic       n;
      logic       z;
      logic       c;
    } f;
  } sr_word_t;

endpackage
